// File: logic/exec_pkg.sv
`default_nettype none

package exec_pkg;

    parameter int XLEN = 32;
    // one quotient bit per cycle plus the operand load cycle
    parameter int DIV_CYCLES = XLEN + 1;

    typedef logic [XLEN-1:0] word_t;
    // hi in the upper word, lo in the lower word
    typedef logic [2*XLEN-1:0] dword_t;

    typedef enum logic [3:0] {
        ADD, ADDU, SUB, SUBU, AND, OR, XOR, NOR,
        SLT, SLTU, SLL, SRL, SRA, LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        BEQ, BNE, BLEZ, BGTZ, BLTZ, BGEZ
    } br_type_e;

    typedef enum logic [1:0] {
        MSIZE1, MSIZE2, MSIZE4
    } msize_e;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_view_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_view_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] index26;
    } j_view_t;

    // same instruction word seen as R, I or J format
    typedef union packed {
        r_view_t r_view;
        i_view_t i_view;
        j_view_t j_view;
    } instr_u;

endpackage

`default_nettype wire

// File: logic/operand_hold.sv
`default_nettype none

module operand_hold import exec_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst_n_i,
    input  wire logic  stall_i,
    input  wire word_t rd1_i,
    input  wire word_t rd2_i,
    input  wire logic  byp1_en_i,
    input  wire word_t byp1_data_i,
    input  wire logic  byp2_en_i,
    input  wire word_t byp2_data_i,
    output word_t      src_a_o,
    output word_t      src_b_o
);

    word_t save_a_q;
    word_t save_b_q;
    logic  saved_a_q;
    logic  saved_b_q;

    // live bypass first, then the value caught during the stall
    always_comb begin
        src_a_o = rd1_i;
        if (byp1_en_i) begin
            src_a_o = byp1_data_i;
        end else if (saved_a_q) begin
            src_a_o = save_a_q;
        end
        src_b_o = rd2_i;
        if (byp2_en_i) begin
            src_b_o = byp2_data_i;
        end else if (saved_b_q) begin
            src_b_o = save_b_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            saved_a_q <= 1'b0;
            saved_b_q <= 1'b0;
        end else if (!stall_i) begin
            saved_a_q <= 1'b0;
            saved_b_q <= 1'b0;
        end else begin
            saved_a_q <= saved_a_q | byp1_en_i;
            saved_b_q <= saved_b_q | byp2_en_i;
        end
    end

    // forwarded data that would vanish while stalled
    always_ff @(posedge clk) begin
        if (stall_i && byp1_en_i) begin
            save_a_q <= byp1_data_i;
        end
        if (stall_i && byp2_en_i) begin
            save_b_q <= byp2_data_i;
        end
    end

endmodule

`default_nettype wire

// File: logic/int_alu.sv
`default_nettype none

module int_alu import exec_pkg::*; (
    input  wire word_t   src_a_i,
    input  wire word_t   src_b_i,
    input  wire instr_u  instr_i,
    input  wire alu_op_e alu_op_i,
    input  wire logic    alusrc_imm_i,
    input  wire logic    zeroext_i,
    input  wire logic    shamt_valid_i,
    output word_t        alu_out_o,
    output logic         overflow_o
);

    word_t ext_imm;
    word_t op_a;
    word_t op_b;
    word_t sum;
    word_t diff;
    logic  add_ovf;
    logic  sub_ovf;

    assign ext_imm = zeroext_i ? {16'b0, instr_i.i_view.imm16}
                               : {{16{instr_i.i_view.imm16[15]}}, instr_i.i_view.imm16};

    // shamt field replaces rs for constant shifts
    assign op_a = shamt_valid_i ? {27'b0, instr_i.r_view.shamt} : src_a_i;
    assign op_b = alusrc_imm_i ? ext_imm : src_b_i;

    assign sum  = op_a + op_b;
    assign diff = op_a - op_b;

    // same-sign inputs give a result of the other sign
    assign add_ovf = (op_a[XLEN-1] == op_b[XLEN-1]) && (sum[XLEN-1] != op_a[XLEN-1]);
    assign sub_ovf = (op_a[XLEN-1] != op_b[XLEN-1]) && (diff[XLEN-1] != op_a[XLEN-1]);

    always_comb begin
        overflow_o = 1'b0;
        case (alu_op_i)
            ADD: begin
                alu_out_o  = sum;
                overflow_o = add_ovf;
            end
            ADDU: alu_out_o = sum;
            SUB: begin
                alu_out_o  = diff;
                overflow_o = sub_ovf;
            end
            SUBU: alu_out_o = diff;
            AND:  alu_out_o = op_a & op_b;
            OR:   alu_out_o = op_a | op_b;
            XOR:  alu_out_o = op_a ^ op_b;
            NOR:  alu_out_o = ~(op_a | op_b);
            SLT:  alu_out_o = word_t'($signed(op_a) < $signed(op_b));
            SLTU: alu_out_o = word_t'(op_a < op_b);
            SLL:  alu_out_o = op_b << op_a[4:0];
            SRL:  alu_out_o = op_b >> op_a[4:0];
            SRA:  alu_out_o = word_t'($signed(op_b) >>> op_a[4:0]);
            LUI:  alu_out_o = {instr_i.i_view.imm16, 16'b0};
            default: alu_out_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/branch_unit.sv
`default_nettype none

module branch_unit import exec_pkg::*; (
    input  wire word_t    pc_i,
    input  wire instr_u   instr_i,
    input  wire word_t    src_a_i,
    input  wire word_t    src_b_i,
    input  wire logic     branch_i,
    input  wire br_type_e br_type_i,
    input  wire logic     jump_i,
    input  wire logic     jr_i,
    input  wire logic     pred_taken_i,
    input  wire word_t    pred_pc_i,
    output logic          branch_cond_o,
    output logic          redirect_o,
    output word_t         target_o,
    output word_t         dest_pc_o
);

    word_t slot_pc;
    word_t br_dest;
    word_t j_dest;
    logic  cond;

    assign slot_pc = pc_i + 32'd4;
    assign br_dest = slot_pc + {{14{instr_i.i_view.imm16[15]}}, instr_i.i_view.imm16, 2'b00};
    // region of the delay slot, not of the jump itself
    assign j_dest  = {slot_pc[31:28], instr_i.j_view.index26, 2'b00};

    always_comb begin
        case (br_type_i)
            BEQ:     cond = (src_a_i == src_b_i);
            BNE:     cond = (src_a_i != src_b_i);
            BLEZ:    cond = ($signed(src_a_i) <= 0);
            BGTZ:    cond = ($signed(src_a_i) > 0);
            BLTZ:    cond = src_a_i[XLEN-1];
            BGEZ:    cond = !src_a_i[XLEN-1];
            default: cond = 1'b0;
        endcase
    end

    assign branch_cond_o = branch_i && cond;

    always_comb begin
        dest_pc_o = '0;
        if (branch_i) begin
            dest_pc_o = br_dest;
        end else if (jr_i) begin
            dest_pc_o = src_a_i;
        end else if (jump_i) begin
            dest_pc_o = j_dest;
        end
    end

    always_comb begin
        redirect_o = 1'b0;
        target_o   = '0;
        if (branch_i) begin
            // front end guessed wrong in either direction
            redirect_o = (cond != pred_taken_i);
            target_o   = cond ? br_dest : pc_i + 32'd8;
        end else if (jump_i || jr_i) begin
            redirect_o = !(pred_taken_i && (pred_pc_i == dest_pc_o));
            target_o   = dest_pc_o;
        end
    end

endmodule

`default_nettype wire

// File: logic/muldiv_unit.sv
`default_nettype none

module muldiv_unit import exec_pkg::*; #(
    parameter int MUL_STAGES = 3
) (
    input  wire logic  clk,
    input  wire logic  rst_n_i,
    input  wire logic  mul_i,
    input  wire logic  div_i,
    input  wire logic  signed_i,
    input  wire logic  d_wait_i,
    input  wire word_t src_a_i,
    input  wire word_t src_b_i,
    output word_t      hi_o,
    output word_t      lo_o,
    output logic       wait_o
);

    localparam int MAX_CYC = (MUL_STAGES > DIV_CYCLES) ? MUL_STAGES : DIV_CYCLES;
    localparam int CNT_W = $clog2(MAX_CYC + 1);
    localparam logic [CNT_W-1:0] MUL_LAST = CNT_W'(MUL_STAGES - 1);
    localparam logic [CNT_W-1:0] DIV_LAST = CNT_W'(DIV_CYCLES - 1);

    logic             op_held;
    logic             start;
    logic             done;
    logic             neg_a;
    logic             neg_b;
    word_t            mag_a;
    word_t            mag_b;
    logic             busy_q;
    logic [CNT_W-1:0] cnt_q;
    logic             is_div_q;
    logic             neg_a_q;
    logic             neg_b_q;
    dword_t           pipe_q [MUL_STAGES];
    word_t            dvsr_q;
    word_t            quo_q;
    word_t            rem_q;
    logic [XLEN:0]    shifted;
    logic [XLEN:0]    trial;
    dword_t           prod;

    assign op_held = mul_i || div_i;
    assign start   = op_held && !busy_q;
    assign done    = busy_q && (cnt_q == (is_div_q ? DIV_LAST : MUL_LAST));
    assign wait_o  = op_held && !done;

    // work on magnitudes, fix the signs at the output
    assign neg_a = signed_i && src_a_i[XLEN-1];
    assign neg_b = signed_i && src_b_i[XLEN-1];
    assign mag_a = neg_a ? -src_a_i : src_a_i;
    assign mag_b = neg_b ? -src_b_i : src_b_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (!busy_q) begin
            if (op_held) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end
        end else if (done) begin
            // result held under back-pressure
            if (!d_wait_i) begin
                busy_q <= 1'b0;
            end
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // restoring divider step
    assign shifted = {rem_q, quo_q[XLEN-1]};
    assign trial   = shifted - {1'b0, dvsr_q};

    always_ff @(posedge clk) begin
        if (start) begin
            is_div_q  <= div_i;
            neg_a_q   <= neg_a;
            neg_b_q   <= neg_b;
            dvsr_q    <= mag_b;
            quo_q     <= mag_a;
            rem_q     <= '0;
            pipe_q[0] <= dword_t'(mag_a) * dword_t'(mag_b);
        end else if (busy_q && !done) begin
            for (int i = 1; i < MUL_STAGES; i++) begin
                pipe_q[i] <= pipe_q[i-1];
            end
            if (is_div_q) begin
                rem_q <= trial[XLEN] ? shifted[XLEN-1:0] : trial[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], !trial[XLEN]};
            end
        end
    end

    assign prod = (neg_a_q ^ neg_b_q) ? -pipe_q[MUL_STAGES-1] : pipe_q[MUL_STAGES-1];

    always_comb begin
        hi_o = '0;
        lo_o = '0;
        if (op_held && is_div_q) begin
            // remainder follows the dividend
            hi_o = neg_a_q ? -rem_q : rem_q;
            lo_o = (neg_a_q ^ neg_b_q) ? -quo_q : quo_q;
        end else if (op_held) begin
            hi_o = prod[2*XLEN-1:XLEN];
            lo_o = prod[XLEN-1:0];
        end
    end

endmodule

`default_nettype wire

// File: logic/exception_check.sv
`default_nettype none

module exception_check import exec_pkg::*; (
    input  wire logic   valid_i,
    input  wire word_t  addr_i,
    input  wire msize_e msize_i,
    input  wire logic   mem_read_i,
    input  wire logic   mem_write_i,
    input  wire logic   overflow_i,
    output logic        exc_overflow_o,
    output logic        exc_adel_o,
    output logic        exc_ades_o,
    output logic        mem_read_o,
    output logic        mem_write_o,
    output logic        valid_o
);

    logic misalign;

    // byte accesses are always aligned
    assign misalign = ((msize_i == MSIZE2) && addr_i[0])
                   || ((msize_i == MSIZE4) && (addr_i[1:0] != 2'b00));

    assign exc_adel_o = mem_read_i && misalign;
    assign exc_ades_o = mem_write_i && misalign;

    assign exc_overflow_o = overflow_i;

    // a faulting access must not reach the cache
    assign mem_read_o  = mem_read_i && !misalign;
    assign mem_write_o = mem_write_i && !misalign && !overflow_i;

    assign valid_o = valid_i;

endmodule

`default_nettype wire

// File: logic/exec_stage.sv
`default_nettype none

module exec_stage import exec_pkg::*; #(
    parameter int MUL_STAGES = 3
) (
    input  wire logic     clk,
    input  wire logic     rst_n_i,
    input  wire logic     valid_i,
    input  wire word_t    pc_i,
    input  wire instr_u   instr_i,
    input  wire word_t    rd1_i,
    input  wire word_t    rd2_i,
    input  wire logic     byp1_en_i,
    input  wire word_t    byp1_data_i,
    input  wire logic     byp2_en_i,
    input  wire word_t    byp2_data_i,
    input  wire alu_op_e  alu_op_i,
    input  wire logic     alusrc_imm_i,
    input  wire logic     zeroext_i,
    input  wire logic     shamt_valid_i,
    input  wire logic     branch_i,
    input  wire br_type_e br_type_i,
    input  wire logic     jump_i,
    input  wire logic     jr_i,
    input  wire logic     is_link_i,
    input  wire logic     pred_taken_i,
    input  wire word_t    pred_pc_i,
    input  wire logic     mul_i,
    input  wire logic     div_i,
    input  wire logic     signed_i,
    input  wire logic     mem_read_i,
    input  wire logic     mem_write_i,
    input  wire msize_e   msize_i,
    input  wire logic     d_wait_i,
    output word_t         result_o,
    output word_t         srca_o,
    output word_t         srcb_o,
    output word_t         hi_o,
    output word_t         lo_o,
    output logic          redirect_o,
    output word_t         target_o,
    output word_t         dest_pc_o,
    output logic          branch_cond_o,
    output logic          exc_overflow_o,
    output logic          exc_adel_o,
    output logic          exc_ades_o,
    output logic          mem_read_o,
    output logic          mem_write_o,
    output logic          valid_o,
    output logic          e_wait_o
);

    logic  stall;
    word_t alu_out;
    logic  overflow;

    // own multicycle wait or back-pressure from the memory stage
    assign stall = e_wait_o || d_wait_i;

    operand_hold u_hold (
        .clk, .rst_n_i, .stall_i(stall), .rd1_i, .rd2_i,
        .byp1_en_i, .byp1_data_i, .byp2_en_i, .byp2_data_i,
        .src_a_o(srca_o), .src_b_o(srcb_o)
    );

    int_alu u_alu (
        .src_a_i(srca_o), .src_b_i(srcb_o), .instr_i, .alu_op_i,
        .alusrc_imm_i, .zeroext_i, .shamt_valid_i,
        .alu_out_o(alu_out), .overflow_o(overflow)
    );

    branch_unit u_branch (
        .pc_i, .instr_i, .src_a_i(srca_o), .src_b_i(srcb_o), .branch_i, .br_type_i,
        .jump_i, .jr_i, .pred_taken_i, .pred_pc_i,
        .branch_cond_o, .redirect_o, .target_o, .dest_pc_o
    );

    muldiv_unit #(.MUL_STAGES(MUL_STAGES)) u_muldiv (
        .clk, .rst_n_i, .mul_i, .div_i, .signed_i, .d_wait_i,
        .src_a_i(srca_o), .src_b_i(srcb_o), .hi_o, .lo_o, .wait_o(e_wait_o)
    );

    exception_check u_exc (
        .valid_i, .addr_i(alu_out), .msize_i, .mem_read_i, .mem_write_i,
        .overflow_i(overflow), .exc_overflow_o, .exc_adel_o, .exc_ades_o,
        .mem_read_o, .mem_write_o, .valid_o
    );

    // return address skips the delay slot
    assign result_o = is_link_i ? pc_i + 32'd8 : alu_out;

endmodule

`default_nettype wire

// File: dv/exec_ref.svh
`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

// operand selection as the stage decodes the instruction
function automatic word_t alu_model(
    input alu_op_e op, input word_t a, input word_t b, input instr_u ins,
    input logic use_imm, input logic zext, input logic use_shamt, output logic ovf
);
    word_t  x;
    word_t  y;
    longint wide;
    x = use_shamt ? word_t'(ins.r_view.shamt) : a;
    y = !use_imm ? b
      : zext     ? word_t'(ins.i_view.imm16)
                 : word_t'(longint'($signed(ins.i_view.imm16)));
    wide = (op == SUB) ? longint'($signed(x)) - longint'($signed(y))
                       : longint'($signed(x)) + longint'($signed(y));
    // true result outside the signed 32-bit range
    ovf = ((op == ADD) || (op == SUB))
       && ((wide > 64'sd2147483647) || (wide < -64'sd2147483648));
    case (op)
        ADD, ADDU: return x + y;
        SUB, SUBU: return x - y;
        AND:       return x & y;
        OR:        return x | y;
        XOR:       return x ^ y;
        NOR:       return ~(x | y);
        SLT:       return (longint'($signed(x)) < longint'($signed(y))) ? 32'd1 : 32'd0;
        SLTU:      return (longint'(x) < longint'(y)) ? 32'd1 : 32'd0;
        SLL:       return y << x[4:0];
        SRL:       return y >> x[4:0];
        SRA:       return word_t'(longint'($signed(y)) >>> x[4:0]);
        LUI:       return {ins.i_view.imm16, 16'h0000};
        default:   return '0;
    endcase
endfunction

function automatic void branch_model(
    input word_t pc, input instr_u ins, input word_t a, input word_t b,
    input logic is_br, input br_type_e bt, input logic is_j, input logic is_jr,
    input logic pred, input word_t pred_pc,
    output logic cond, output logic redirect, output word_t target, output word_t dest
);
    longint sa;
    logic   taken;
    word_t  slot;
    sa   = longint'($signed(a));
    slot = pc + 32'd4;
    case (bt)
        BEQ:     taken = (a == b);
        BNE:     taken = (a != b);
        BLEZ:    taken = (sa <= 0);
        BGTZ:    taken = (sa > 0);
        BLTZ:    taken = (sa < 0);
        default: taken = (sa >= 0);
    endcase
    cond     = is_br && taken;
    redirect = 1'b0;
    target   = '0;
    dest     = '0;
    if (is_br) begin
        dest     = word_t'(longint'(slot) + 4 * longint'($signed(ins.i_view.imm16)));
        redirect = (taken != pred);
        target   = taken ? dest : pc + 32'd8;
    end else if (is_j || is_jr) begin
        dest     = is_jr ? a : {slot[31:28], ins.j_view.index26, 2'b00};
        redirect = !(pred && (pred_pc == dest));
        target   = dest;
    end
endfunction

// remainder in hi and quotient in lo for a divide
function automatic dword_t muldiv_model(input logic is_div, input logic sgn,
                                        input word_t a, input word_t b);
    longint sa;
    longint sb;
    sa = sgn ? longint'($signed(a)) : longint'(a);
    sb = sgn ? longint'($signed(b)) : longint'(b);
    if (!is_div) begin
        return dword_t'(sa * sb);
    end
    return {word_t'(sa % sb), word_t'(sa / sb)};
endfunction

function automatic logic misaligned(input msize_e size, input word_t addr);
    case (size)
        MSIZE2:  return (addr % 2) != 0;
        MSIZE4:  return (addr % 4) != 0;
        default: return 1'b0;
    endcase
endfunction

`endif

// File: dv/exec_tb.sv
`default_nettype none

module exec_tb import exec_pkg::*; ();

    localparam int MUL_STAGES = 3;
    localparam int ALU_REPS = 8;
    localparam int FWD_REPS = 6;
    localparam int BR_REPS = 4;
    localparam int JMP_REPS = 16;
    localparam int MD_REPS = 6;
    localparam int MEM_REPS = 6;
    localparam int N_TESTS = 14 * ALU_REPS + FWD_REPS + 12 * BR_REPS + JMP_REPS
                           + 4 * MD_REPS + 2 + 6 * MEM_REPS + 1;
    localparam int CYCLE_LIMIT = N_TESTS * (XLEN + 1 + 8) + 16;

    localparam logic [4:0] CHK_ALU = 5'b00001;
    localparam logic [4:0] CHK_SRC = 5'b00010;
    localparam logic [4:0] CHK_BR  = 5'b00100;
    localparam logic [4:0] CHK_MD  = 5'b01000;
    localparam logic [4:0] CHK_MEM = 5'b10000;

    logic     clk = 1'b0;
    logic     rst_n_i;
    logic     valid_i, byp1_en_i, byp2_en_i, alusrc_imm_i, zeroext_i, shamt_valid_i;
    logic     branch_i, jump_i, jr_i, is_link_i, pred_taken_i;
    logic     mul_i, div_i, signed_i, mem_read_i, mem_write_i, d_wait_i;
    word_t    pc_i, rd1_i, rd2_i, byp1_data_i, byp2_data_i, pred_pc_i;
    instr_u   instr_i;
    alu_op_e  alu_op_i;
    br_type_e br_type_i;
    msize_e   msize_i;
    word_t    result_o, srca_o, srcb_o, hi_o, lo_o, target_o, dest_pc_o;
    logic     redirect_o, branch_cond_o, exc_overflow_o, exc_adel_o, exc_ades_o;
    logic     mem_read_o, mem_write_o, valid_o, e_wait_o;

    // expected values set with the stimulus and compared at the next rising edge
    logic [4:0] chk_mode;
    word_t      exp_result, exp_srca, exp_srcb, exp_target, exp_dest;
    logic       exp_ovf, exp_cond, exp_redirect, exp_adel, exp_ades, exp_mrd, exp_mwr;
    dword_t     exp_hilo;
    logic [31:0] lfsr_state;
    int         cycle_cnt = 0;

    `include "exec_ref.svh"

    exec_stage #(.MUL_STAGES(MUL_STAGES)) dut_i (.*);

    always #2 clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_dword(input string name, input dword_t got, input dword_t exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch %s got %h expected %h", name, got, exp));
        end
    endtask

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic rand_bit();
        lfsr_state = lfsr_next(lfsr_state);
        return lfsr_state[0];
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[XLEN-2:0], rand_bit()};
        end
        return v;
    endfunction

    always @(posedge clk) begin
        if ((chk_mode & CHK_ALU) != 0) begin
            check_word("result_o", result_o, exp_result);
            check_flag("exc_overflow_o", exc_overflow_o, exp_ovf);
        end
        if ((chk_mode & CHK_SRC) != 0) begin
            check_word("srca_o", srca_o, exp_srca);
            check_word("srcb_o", srcb_o, exp_srcb);
        end
        if ((chk_mode & CHK_BR) != 0) begin
            check_flag("branch_cond_o", branch_cond_o, exp_cond);
            check_flag("redirect_o", redirect_o, exp_redirect);
            check_word("target_o", target_o, exp_target);
            check_word("dest_pc_o", dest_pc_o, exp_dest);
        end
        if ((chk_mode & CHK_MD) != 0) begin
            check_dword("hi_o:lo_o", {hi_o, lo_o}, exp_hilo);
            check_flag("e_wait_o", e_wait_o, 1'b0);
        end
        if ((chk_mode & CHK_MEM) != 0) begin
            check_flag("exc_adel_o", exc_adel_o, exp_adel);
            check_flag("exc_ades_o", exc_ades_o, exp_ades);
            check_flag("mem_read_o", mem_read_o, exp_mrd);
            check_flag("mem_write_o", mem_write_o, exp_mwr);
            check_flag("valid_o", valid_o, valid_i);
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            stop_run($sformatf("error: run did not finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    task automatic drive_defaults();
        valid_i       = 1'b0;
        pc_i          = '0;
        instr_i       = '0;
        rd1_i         = '0;
        rd2_i         = '0;
        byp1_en_i     = 1'b0;
        byp1_data_i   = '0;
        byp2_en_i     = 1'b0;
        byp2_data_i   = '0;
        alu_op_i      = ADDU;
        alusrc_imm_i  = 1'b0;
        zeroext_i     = 1'b0;
        shamt_valid_i = 1'b0;
        branch_i      = 1'b0;
        br_type_i     = BEQ;
        jump_i        = 1'b0;
        jr_i          = 1'b0;
        is_link_i     = 1'b0;
        pred_taken_i  = 1'b0;
        pred_pc_i     = '0;
        mul_i         = 1'b0;
        div_i         = 1'b0;
        signed_i      = 1'b0;
        mem_read_i    = 1'b0;
        mem_write_i   = 1'b0;
        msize_i       = MSIZE1;
        d_wait_i      = 1'b0;
        chk_mode      = '0;
    endtask

    task automatic expect_control_flow();
        branch_model(pc_i, instr_i, rd1_i, rd2_i, branch_i, br_type_i, jump_i, jr_i,
                     pred_taken_i, pred_pc_i, exp_cond, exp_redirect, exp_target, exp_dest);
        exp_result = alu_model(alu_op_i, rd1_i, rd2_i, instr_i, alusrc_imm_i, zeroext_i,
                               shamt_valid_i, exp_ovf);
        // return address past the delay slot
        if (is_link_i) begin
            exp_result = pc_i + 32'd8;
        end
        chk_mode = CHK_ALU | CHK_BR;
    endtask

    task automatic expect_memory();
        logic mis;
        exp_result = alu_model(alu_op_i, rd1_i, rd2_i, instr_i, alusrc_imm_i, zeroext_i,
                               shamt_valid_i, exp_ovf);
        mis      = misaligned(msize_i, exp_result);
        exp_adel = mem_read_i && mis;
        exp_ades = mem_write_i && mis;
        exp_mrd  = mem_read_i && !mis;
        exp_mwr  = mem_write_i && !mis && !exp_ovf;
        chk_mode = CHK_ALU | CHK_MEM;
    endtask

    task automatic alu_tests();
        for (int k = 0; k < 14; k++) begin
            for (int n = 0; n < ALU_REPS; n++) begin
                @(negedge clk);
                drive_defaults();
                valid_i       = 1'b1;
                alu_op_i      = alu_op_e'(k);
                rd1_i         = rand_bits(32);
                rd2_i         = rand_bits(32);
                instr_i       = instr_u'(rand_bits(32));
                alusrc_imm_i  = rand_bit();
                zeroext_i     = rand_bit();
                shamt_valid_i = rand_bit();
                // no control flow, so the branch outputs stay at zero
                expect_control_flow();
            end
        end
    endtask

    task automatic forwarding_test();
        logic en_a;
        logic en_b;
        for (int n = 0; n < FWD_REPS; n++) begin
            @(negedge clk);
            drive_defaults();
            valid_i     = 1'b1;
            d_wait_i    = 1'b1;
            rd1_i       = rand_bits(32);
            rd2_i       = rand_bits(32);
            en_a        = rand_bit();
            en_b        = rand_bit() || !en_a;
            byp1_en_i   = en_a;
            byp1_data_i = rand_bits(32);
            byp2_en_i   = en_b;
            byp2_data_i = rand_bits(32);
            exp_srca    = en_a ? byp1_data_i : rd1_i;
            exp_srcb    = en_b ? byp2_data_i : rd2_i;
            chk_mode    = CHK_SRC;
            // bypass gone while still stalled
            @(negedge clk);
            byp1_en_i   = 1'b0;
            byp2_en_i   = 1'b0;
            byp1_data_i = rand_bits(32);
            byp2_data_i = rand_bits(32);
            @(negedge clk);
            d_wait_i = 1'b0;
            // next instruction reads the register file again
            @(negedge clk);
            rd1_i    = rand_bits(32);
            rd2_i    = rand_bits(32);
            exp_srca = rd1_i;
            exp_srcb = rd2_i;
        end
    endtask

    task automatic branch_tests();
        logic [1:0] pick;
        for (int k = 0; k < 6; k++) begin
            for (int p = 0; p < 2; p++) begin
                for (int n = 0; n < BR_REPS; n++) begin
                    @(negedge clk);
                    drive_defaults();
                    valid_i = 1'b1;
                    pick    = 2'(rand_bits(2));
                    // zero and equal operands hit the boundary cases
                    rd1_i        = (pick == 2'd0) ? '0 : rand_bits(32);
                    rd2_i        = (pick == 2'd1) ? rd1_i : rand_bits(32);
                    pc_i         = rand_bits(30) << 2;
                    instr_i      = instr_u'(rand_bits(32));
                    branch_i     = 1'b1;
                    br_type_i    = br_type_e'(k);
                    pred_taken_i = p[0];
                    is_link_i    = rand_bit();
                    expect_control_flow();
                end
            end
        end
    endtask

    task automatic jump_tests();
        for (int n = 0; n < JMP_REPS; n++) begin
            @(negedge clk);
            drive_defaults();
            valid_i      = 1'b1;
            pc_i         = rand_bits(30) << 2;
            instr_i      = instr_u'(rand_bits(32));
            rd1_i        = rand_bits(32);
            rd2_i        = rand_bits(32);
            jr_i         = n[0];
            jump_i       = !n[0];
            pred_taken_i = rand_bit();
            is_link_i    = rand_bit();
            pred_pc_i    = rand_bits(32);
            expect_control_flow();
            if (rand_bit()) begin
                pred_pc_i = exp_dest;
                expect_control_flow();
            end
        end
    endtask

    task automatic muldiv_op(input logic is_div, input logic sgn, input int bp_cycles);
        int n;
        @(negedge clk);
        drive_defaults();
        valid_i = 1'b1;
        rd1_i   = rand_bits(32);
        rd2_i   = rand_bits(32);
        if (is_div && (rd2_i == '0)) begin
            rd2_i = 32'd7;
        end
        mul_i    = !is_div;
        div_i    = is_div;
        signed_i = sgn;
        d_wait_i = (bp_cycles > 0);
        exp_hilo = muldiv_model(is_div, sgn, rd1_i, rd2_i);
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > DIV_CYCLES + 8) begin
                stop_run($sformatf("error: stall never released after %0d cycles", n));
            end
        end while (e_wait_o);
        check_word("mul/div latency", word_t'(n), word_t'(is_div ? DIV_CYCLES : MUL_STAGES));
        chk_mode = CHK_MD;
        // result must hold while the next stage is not ready
        repeat (bp_cycles) @(negedge clk);
        d_wait_i = 1'b0;
        @(negedge clk);
        drive_defaults();
    endtask

    task automatic align_tests();
        for (int k = 0; k < 3; k++) begin
            for (int st = 0; st < 2; st++) begin
                for (int n = 0; n < MEM_REPS; n++) begin
                    @(negedge clk);
                    drive_defaults();
                    valid_i     = rand_bit();
                    alu_op_i    = rand_bit() ? ADD : ADDU;
                    rd1_i       = rand_bits(32);
                    rd2_i       = rand_bits(3);
                    msize_i     = msize_e'(k);
                    mem_read_i  = !st[0];
                    mem_write_i = st[0];
                    expect_memory();
                end
            end
        end
        // aligned store whose address add overflows
        @(negedge clk);
        drive_defaults();
        valid_i     = 1'b1;
        alu_op_i    = ADD;
        rd1_i       = 32'h7fff_fff0;
        rd2_i       = 32'h0000_0010;
        msize_i     = MSIZE4;
        mem_write_i = 1'b1;
        expect_memory();
    endtask

    initial begin
        lfsr_state = 32'hb1f44a42;
        rst_n_i    = 1'b0;
        drive_defaults();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        check_flag("e_wait_o", e_wait_o, 1'b0);
        alu_tests();
        forwarding_test();
        branch_tests();
        jump_tests();
        for (int k = 0; k < 4; k++) begin
            for (int n = 0; n < MD_REPS; n++) begin
                muldiv_op(k[1], k[0], 0);
            end
        end
        muldiv_op(1'b0, 1'b1, 4);
        muldiv_op(1'b0, 1'b0, 3);
        align_tests();
        @(negedge clk);
        drive_defaults();
        @(negedge clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+dv
logic/exec_pkg.sv
logic/operand_hold.sv
logic/int_alu.sv
logic/branch_unit.sv
logic/muldiv_unit.sv
logic/exception_check.sv
logic/exec_stage.sv
dv/exec_tb.sv
